//--- tests/blkenc_vectors.txt
# key(hex) v(hex) expected_ciphertext(hex) cmd(hex) id(hex) backpressure_delay(dec)
# AES-256 known answers: FIPS-197 C.3, SP 800-38A F.1.5 ECB, all-zero key and block
000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089 1 3 0
603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8 2 a 0
603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870 5 7 3
603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d 7 f 0
603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7 0 0 5
0000000000000000000000000000000000000000000000000000000000000000 00000000000000000000000000000000 dc95c078a2408989ad48a21492842087 4 9 1

//--- list.f
logic/csrng_pkg.sv
logic/aes_sbox.sv
logic/aes_key_expand.sv
logic/aes_round.sv
logic/aes_cipher_ctrl.sv
logic/csrng_blkenc_fifo.sv
logic/csrng_block_encrypt.sv
tests/csrng_block_encrypt_properties.sv
tests/csrng_block_encrypt_tb.sv

//--- Bender.yml
package:
  name: csrng_block_encrypt

sources:
  - logic/csrng_pkg.sv
  - logic/aes_sbox.sv
  - logic/aes_key_expand.sv
  - logic/aes_round.sv
  - logic/aes_cipher_ctrl.sv
  - logic/csrng_blkenc_fifo.sv
  - logic/csrng_block_encrypt.sv
  - target: test
    files:
      - tests/csrng_block_encrypt_properties.sv
      - tests/csrng_block_encrypt_tb.sv

//--- tests/csrng_block_encrypt_tb.sv
// ------------------------------------------------
// Testbench for the block encrypt stage
// Vectors come from tests/blkenc_vectors.txt, run
// from the project root; one block in flight at a time
// ------------------------------------------------

`default_nettype none

module csrng_block_encrypt_tb import csrng_pkg::*;;

  localparam int unsigned Cmd         = 3;
  localparam int unsigned StateId     = 4;
  localparam int unsigned Latency     = 15;
  localparam int unsigned GatedVector = 1;

  logic               clk;
  logic               rst;
  logic               enable;
  logic               req;
  logic               rdy;
  key_t               key;
  blk_t               v;
  logic [Cmd-1:0]     cmd;
  logic [StateId-1:0] id;
  logic               out_rdy;
  logic               ack;
  logic [Cmd-1:0]     cmd_out;
  logic [StateId-1:0] id_out;
  blk_t               v_out;
  logic               quiet;
  logic               sm_err;
  logic [2:0]         sfifo_err;

  key_t        vec_key [$];
  blk_t        vec_v [$];
  blk_t        vec_exp [$];
  logic [7:0]  vec_cmd [$];
  logic [7:0]  vec_id [$];
  int unsigned vec_delay [$];
  int unsigned num_vectors;
  logic        vectors_loaded;
  int unsigned error_count;

  csrng_block_encrypt #(
    .Cmd     (Cmd),
    .StateId (StateId)
  ) uut (
    .clk_i                             (clk),
    .rst_i                             (rst),
    .block_encrypt_enable_i            (enable),
    .block_encrypt_req_i               (req),
    .block_encrypt_rdy_o               (rdy),
    .block_encrypt_key_i               (key),
    .block_encrypt_v_i                 (v),
    .block_encrypt_cmd_i               (cmd),
    .block_encrypt_id_i                (id),
    .block_encrypt_ack_o               (ack),
    .block_encrypt_rdy_i               (out_rdy),
    .block_encrypt_cmd_o               (cmd_out),
    .block_encrypt_id_o                (id_out),
    .block_encrypt_v_o                 (v_out),
    .block_encrypt_quiet_o             (quiet),
    .block_encrypt_aes_cipher_sm_err_o (sm_err),
    .block_encrypt_sfifo_blkenc_err_o  (sfifo_err)
  );

  always #2 clk = ~clk;

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------
  // Vector file
  // ------------------------------------------------

  task automatic read_vectors();
    int    fd;
    int    fields;
    string line;
    key_t  k;
    blk_t  pt;
    blk_t  ct;
    int    c;
    int    i;
    int    d;
    fd = $fopen("tests/blkenc_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tests/blkenc_vectors.txt");
      $display("STATUS: FAIL");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %d", k, pt, ct, c, i, d);
        if (fields != 6) begin
          $display("Malformed line in the vector file: %s", line);
          $display("STATUS: FAIL");
          $fatal(1);
        end
        vec_key.push_back(k);
        vec_v.push_back(pt);
        vec_exp.push_back(ct);
        vec_cmd.push_back(c[7:0]);
        vec_id.push_back(i[7:0]);
        vec_delay.push_back(d);
      end
    end
    $fclose(fd);
    num_vectors = vec_key.size();
  endtask

  // Request with enable low, carrying a tag that must never come back
  task automatic request_while_disabled(input int unsigned idx);
    @(posedge clk);
    #1 enable = 1'b0;
    @(posedge clk);
    #1;
    req = 1'b1;
    key = vec_key[idx];
    v   = vec_v[idx];
    cmd = ~vec_cmd[idx][Cmd-1:0];
    id  = ~vec_id[idx][StateId-1:0];
    @(negedge clk);
    check_value("gated_rdy", 1'b0, rdy);
    @(posedge clk);
    #1 req = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_value("gated_ack", 1'b0, ack);
      check_value("gated_rdy", 1'b0, rdy);
      check_value("gated_quiet", 1'b1, quiet);
    end
    @(posedge clk);
    #1 enable = 1'b1;
  endtask

  // ------------------------------------------------
  // One block, from request to ack
  // ------------------------------------------------

  task automatic encrypt_vector(input int unsigned idx);
    int unsigned delay;
    blk_t        held_v;
    delay = vec_delay[idx];
    repeat ($urandom % 4) @(posedge clk);
    @(negedge clk);
    check_value("quiet_before_req", 1'b1, quiet);
    check_value("rdy_before_req", 1'b1, rdy);
    @(posedge clk);
    #1;
    req     = 1'b1;
    key     = vec_key[idx];
    v       = vec_v[idx];
    cmd     = vec_cmd[idx][Cmd-1:0];
    id      = vec_id[idx][StateId-1:0];
    out_rdy = (delay == 0);
    @(negedge clk);
    check_value("quiet_on_accept", 1'b0, quiet);
    for (int n = 1; n <= Latency; n++) begin
      @(posedge clk);
      #1;
      if (n == 1) begin
        req = 1'b0;
        key = '0;
        v   = '0;
      end
      @(negedge clk);
      if (n < Latency) begin
        check_value("early_ack", 1'b0, ack);
        check_value("quiet_busy", 1'b0, quiet);
        check_value("rdy_busy", 1'b0, rdy);
      end
    end
    // Result is ready here; stall it for delay cycles
    held_v = v_out;
    for (int k = 0; k < delay; k++) begin
      check_value("ack_while_stalled", 1'b0, ack);
      @(posedge clk);
      #1;
      if (k == delay - 1) begin
        out_rdy = 1'b1;
      end
      @(negedge clk);
      check_value("v_while_stalled", held_v, v_out);
    end
    check_value("ack_at_latency", 1'b1, ack);
    check_value("ciphertext", vec_exp[idx], v_out);
    check_value("cmd_tag", vec_cmd[idx][Cmd-1:0], cmd_out);
    check_value("id_tag", vec_id[idx][StateId-1:0], id_out);
    @(negedge clk);
    check_value("ack_single", 1'b0, ack);
    check_value("quiet_after_ack", 1'b1, quiet);
    check_value("rdy_after_ack", 1'b1, rdy);
  endtask

  // Status errors must never show up after reset
  always @(negedge clk) begin
    if (!rst) begin
      check_value("sm_err", 1'b0, sm_err);
      check_value("sfifo_err", 3'b000, sfifo_err);
    end
  end

  initial begin
    wait (vectors_loaded);
    repeat (40 * num_vectors + 100) @(posedge clk);
    $display("Timeout: the run did not finish in %0d cycles", 40 * num_vectors + 100);
    $display("STATUS: FAIL");
    $fatal(1);
  end

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    enable         = 1'b0;
    req            = 1'b0;
    key            = '0;
    v              = '0;
    cmd            = '0;
    id             = '0;
    out_rdy        = 1'b1;
    vectors_loaded = 1'b0;
    error_count    = 0;
    num_vectors    = 0;
    void'($urandom(13));
    read_vectors();
    if (num_vectors == 0) begin
      $display("The vector file holds no vectors");
      $display("STATUS: FAIL");
      $fatal(1);
    end
    vectors_loaded = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst    = 1'b0;
    enable = 1'b1;
    @(negedge clk);
    check_value("ack_after_reset", 1'b0, ack);
    check_value("quiet_after_reset", 1'b1, quiet);
    for (int unsigned idx = 0; idx < num_vectors; idx++) begin
      if (idx == GatedVector) begin
        request_while_disabled(idx);
      end
      encrypt_vector(idx);
    end
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/csrng_block_encrypt_properties.sv
// ------------------------------------------------
// Handshake and FIFO rules bound into the top level
// Assumes the requester keeps to the input rule
// ------------------------------------------------

`default_nettype none

module csrng_block_encrypt_properties import csrng_pkg::*; (
  input logic       clk_i,
  input logic       rst_i,
  input logic       req_i,
  input logic       rdy_o,
  input logic       out_rdy_i,
  input logic       ack_o,
  input logic       out_valid_i,
  input blk_t       v_o,
  input logic [2:0] err_o
);

  // Ack only when the consumer is ready, and for one cycle
  ack_needs_rdy: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |-> out_rdy_i ##1 !ack_o)
    else $error("ack without rdy_i or held longer than one cycle");

  // Result is held while stalled
  v_held_while_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_i && !ack_o) |=> $stable(v_o))
    else $error("v_o changed under back-pressure");

  rdy_drops_after_accept: assert property (@(posedge clk_i) disable iff (rst_i)
    (rdy_o && req_i) |=> !rdy_o)
    else $error("rdy_o high right after an accept");

  no_fifo_error: assert property (@(posedge clk_i) disable iff (rst_i)
    err_o == 3'b000)
    else $error("tracking FIFO error flagged");

endmodule

bind csrng_block_encrypt csrng_block_encrypt_properties u_properties (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .req_i       (block_encrypt_req_i),
  .rdy_o       (block_encrypt_rdy_o),
  .out_rdy_i   (block_encrypt_rdy_i),
  .ack_o       (block_encrypt_ack_o),
  .out_valid_i (cipher_out_valid),
  .v_o         (block_encrypt_v_o),
  .err_o       (block_encrypt_sfifo_blkenc_err_o)
);

`default_nettype wire

//--- logic/csrng_block_encrypt.sv
// ------------------------------------------------
// CTR_DRBG block encrypt stage, AES-256 forward only
// req is a one-cycle pulse, legal only with rdy_o high
// ack comes 15 cycles after the edge that opens the
// accept cycle when rdy_i is high; one block at a time
// ------------------------------------------------

`default_nettype none

module csrng_block_encrypt import csrng_pkg::*; #(
  parameter int unsigned Cmd     = 3,
  parameter int unsigned StateId = 4
) (
  input  logic               clk_i,
  input  logic               rst_i,

  // Request side
  input  logic               block_encrypt_enable_i,
  input  logic               block_encrypt_req_i,
  output logic               block_encrypt_rdy_o,
  input  key_t               block_encrypt_key_i,
  input  blk_t               block_encrypt_v_i,
  input  logic [Cmd-1:0]     block_encrypt_cmd_i,
  input  logic [StateId-1:0] block_encrypt_id_i,

  // Result side
  output logic               block_encrypt_ack_o,
  input  logic               block_encrypt_rdy_i,
  output logic [Cmd-1:0]     block_encrypt_cmd_o,
  output logic [StateId-1:0] block_encrypt_id_o,
  output blk_t               block_encrypt_v_o,

  // Status
  output logic               block_encrypt_quiet_o,
  output logic               block_encrypt_aes_cipher_sm_err_o,
  output logic [2:0]         block_encrypt_sfifo_blkenc_err_o
);

  logic       cipher_load;
  logic       cipher_step;
  logic       cipher_last_round;
  round_cnt_t cipher_round;
  logic       cipher_out_valid;
  logic       cipher_busy;
  blk_t       round_key;
  logic       sfifo_blkenc_push;
  logic       sfifo_blkenc_full;

  // ------------------------------------------------
  // AES-256 cipher
  // ------------------------------------------------

  aes_cipher_ctrl u_aes_cipher_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .enable_i     (block_encrypt_enable_i),
    .req_i        (block_encrypt_req_i),
    .out_ready_i  (block_encrypt_rdy_i),
    .in_ready_o   (block_encrypt_rdy_o),
    .load_o       (cipher_load),
    .step_o       (cipher_step),
    .last_round_o (cipher_last_round),
    .round_o      (cipher_round),
    .out_valid_o  (cipher_out_valid),
    .busy_o       (cipher_busy),
    .sm_err_o     (block_encrypt_aes_cipher_sm_err_o)
  );

  aes_key_expand u_aes_key_expand (
    .clk_i       (clk_i),
    .load_i      (cipher_load),
    .step_i      (cipher_step),
    .round_i     (cipher_round),
    .key_i       (block_encrypt_key_i),
    .round_key_o (round_key)
  );

  // First key half is round key 0
  aes_round u_aes_round (
    .clk_i        (clk_i),
    .load_i       (cipher_load),
    .step_i       (cipher_step),
    .last_round_i (cipher_last_round),
    .v_i          (block_encrypt_v_i),
    .key_hi_i     (block_encrypt_key_i[KeyLen-1 -: BlkLen]),
    .round_key_i  (round_key),
    .state_o      (block_encrypt_v_o)
  );

  // ------------------------------------------------
  // Command and id tracking
  // ------------------------------------------------

  assign sfifo_blkenc_push   = block_encrypt_req_i && !sfifo_blkenc_full;
  assign block_encrypt_ack_o = cipher_out_valid && block_encrypt_rdy_i;

  csrng_blkenc_fifo #(
    .Cmd     (Cmd),
    .StateId (StateId)
  ) u_csrng_blkenc_fifo (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .clr_i  (!block_encrypt_enable_i),
    .push_i (sfifo_blkenc_push),
    .cmd_i  (block_encrypt_cmd_i),
    .id_i   (block_encrypt_id_i),
    .pop_i  (block_encrypt_ack_o),
    .cmd_o  (block_encrypt_cmd_o),
    .id_o   (block_encrypt_id_o),
    .full_o (sfifo_blkenc_full),
    .err_o  (block_encrypt_sfifo_blkenc_err_o)
  );

  // Quiet when nothing is accepted and the cipher holds no block
  assign block_encrypt_quiet_o = !cipher_load && !cipher_busy;

endmodule

`default_nettype wire

//--- logic/csrng_blkenc_fifo.sv
// ------------------------------------------------
// One-entry tracking FIFO for command and state id
// err_o = {push while full, pop while empty,
//          full and empty together}
// ------------------------------------------------

`default_nettype none

module csrng_blkenc_fifo #(
  parameter int unsigned Cmd     = 3,
  parameter int unsigned StateId = 4
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               clr_i,
  input  logic               push_i,
  input  logic [Cmd-1:0]     cmd_i,
  input  logic [StateId-1:0] id_i,
  input  logic               pop_i,
  output logic [Cmd-1:0]     cmd_o,
  output logic [StateId-1:0] id_o,
  output logic               full_o,
  output logic [2:0]         err_o
);

  logic [Cmd-1:0]     cmd_q;
  logic [StateId-1:0] id_q;
  // Kept apart so a corrupted pair shows up in err_o[0]
  logic               full_q;
  logic               empty_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i) begin
      full_q  <= 1'b0;
      empty_q <= 1'b1;
    end else if (push_i) begin
      full_q  <= 1'b1;
      empty_q <= 1'b0;
    end else if (pop_i) begin
      full_q  <= 1'b0;
      empty_q <= 1'b1;
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      cmd_q <= cmd_i;
      id_q  <= id_i;
    end
  end

  assign cmd_o  = cmd_q;
  assign id_o   = id_q;
  assign full_o = full_q;

  assign err_o = {push_i && full_q, pop_i && empty_q, full_q && empty_q};

endmodule

`default_nettype wire

//--- logic/aes_cipher_ctrl.sv
// ------------------------------------------------
// Cipher control: accept, 14 rounds, hold, error
// The accept cycle is also the load cycle
// CIPHER_ERROR is left only through reset
// ------------------------------------------------

`default_nettype none

module aes_cipher_ctrl import csrng_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       enable_i,
  input  logic       req_i,
  input  logic       out_ready_i,
  output logic       in_ready_o,
  output logic       load_o,
  output logic       step_o,
  output logic       last_round_o,
  output round_cnt_t round_o,
  output logic       out_valid_o,
  output logic       busy_o,
  output logic       sm_err_o
);

  cipher_state_e state_q;
  cipher_state_e state_d;
  round_cnt_t    round_q;
  round_cnt_t    round_d;
  logic          accept;

  // ------------------------------------------------
  // Handshake and datapath strobes
  // ------------------------------------------------

  assign in_ready_o   = (state_q == CIPHER_IDLE) && enable_i;
  assign accept       = in_ready_o && req_i;
  assign load_o       = accept;
  assign step_o       = (state_q == CIPHER_ROUND);
  assign round_o      = round_q;
  assign last_round_o = step_o && (round_q == round_cnt_t'(NumRounds));
  assign out_valid_o  = (state_q == CIPHER_DONE);
  assign busy_o       = step_o || out_valid_o;
  assign sm_err_o     = (state_q == CIPHER_ERROR);

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------

  always_comb begin
    state_d = state_q;
    round_d = round_q;
    case (state_q)
      CIPHER_IDLE: begin
        if (accept) begin
          state_d = CIPHER_ROUND;
          round_d = round_cnt_t'(1);
        end
      end
      CIPHER_ROUND: begin
        if (last_round_o) begin
          state_d = CIPHER_DONE;
        end else begin
          round_d = round_q + round_cnt_t'(1);
        end
      end
      CIPHER_DONE: begin
        // Result is only trusted after a full round count
        if (round_q != round_cnt_t'(NumRounds)) begin
          state_d = CIPHER_ERROR;
        end else if (out_ready_i) begin
          state_d = CIPHER_IDLE;
        end
      end
      CIPHER_ERROR: begin
        state_d = CIPHER_ERROR;
      end
      default: begin
        state_d = CIPHER_ERROR;
      end
    endcase

    // Dropping enable aborts any block in flight
    if (!enable_i && (state_d != CIPHER_ERROR)) begin
      state_d = CIPHER_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= CIPHER_IDLE;
      round_q <= '0;
    end else begin
      state_q <= state_d;
      round_q <= round_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/aes_round.sv
// ------------------------------------------------
// AES state register and round datapath
// Load does the initial AddRoundKey, each step
// does one round, MixColumns left out on the last
// ------------------------------------------------

`default_nettype none

module aes_round import csrng_pkg::*; (
  input  logic clk_i,
  input  logic load_i,
  input  logic step_i,
  input  logic last_round_i,
  input  blk_t v_i,
  input  blk_t key_hi_i,
  input  blk_t round_key_i,
  output blk_t state_o
);

  blk_t       state_q;
  blk_t       shifted;
  blk_t       mixed;
  blk_t       round_out;
  logic [7:0] sb_out [16];

  // Multiply by x in GF(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // One column, row 0 in the top byte
  function automatic word_t mix_column(input word_t col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // SubBytes, byte n at bits 127-8n
  for (genvar i = 0; i < 16; i++) begin : g_sub_bytes
    aes_sbox u_sbox (
      .in_i  (state_q[BlkLen-1-8*i -: 8]),
      .out_o (sb_out[i])
    );
  end

  // ShiftRows then MixColumns, byte 4c+r is row r of column c
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[BlkLen-1-8*(4*c+r) -: 8] = sb_out[4*((c+r)%4)+r];
      end
    end
    for (int c = 0; c < 4; c++) begin
      mixed[BlkLen-1-32*c -: 32] = mix_column(shifted[BlkLen-1-32*c -: 32]);
    end
  end

  assign round_out = (last_round_i ? shifted : mixed) ^ round_key_i;

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      state_q <= v_i ^ key_hi_i;
    end else if (step_i) begin
      state_q <= round_out;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

//--- logic/aes_key_expand.sv
// ------------------------------------------------
// AES-256 key schedule, one round key per cycle
// Round 1 key is the second key half, later keys
// are derived on the fly from an 8-word window
// ------------------------------------------------

`default_nettype none

module aes_key_expand import csrng_pkg::*; (
  input  logic       clk_i,
  input  logic       load_i,
  input  logic       step_i,
  input  round_cnt_t round_i,
  input  key_t       key_i,
  output blk_t       round_key_o
);

  // Window holds schedule words w[4k-4] .. w[4k+3]
  word_t      win_q [8];
  word_t      sub_in;
  word_t      sub_out;
  word_t      temp;
  word_t      next_w [4];
  logic [7:0] rcon;

  // RotWord only on even rounds
  assign sub_in = round_i[0] ? win_q[7] : {win_q[7][23:0], win_q[7][31:24]};

  for (genvar i = 0; i < 4; i++) begin : g_sub_word
    aes_sbox u_sbox (
      .in_i  (sub_in[8*i +: 8]),
      .out_o (sub_out[8*i +: 8])
    );
  end

  // Rcon index is round/2, giving 01 up to 40
  always_comb begin
    case (round_i[3:1])
      3'd1:    rcon = 8'h01;
      3'd2:    rcon = 8'h02;
      3'd3:    rcon = 8'h04;
      3'd4:    rcon = 8'h08;
      3'd5:    rcon = 8'h10;
      3'd6:    rcon = 8'h20;
      3'd7:    rcon = 8'h40;
      default: rcon = 8'h00;
    endcase
  end

  assign temp = round_i[0] ? sub_out : (sub_out ^ {rcon, 24'h000000});

  // Four new words, each chained on the one before
  always_comb begin
    next_w[0] = win_q[0] ^ temp;
    for (int i = 1; i < 4; i++) begin
      next_w[i] = win_q[i] ^ next_w[i-1];
    end
  end

  assign round_key_o = (round_i == round_cnt_t'(1)) ?
                       {win_q[4], win_q[5], win_q[6], win_q[7]} :
                       {next_w[0], next_w[1], next_w[2], next_w[3]};

  // Slide by four words on every round after the first
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      for (int i = 0; i < 8; i++) begin
        win_q[i] <= key_i[KeyLen-1-32*i -: 32];
      end
    end else if (step_i && (round_i != round_cnt_t'(1))) begin
      for (int i = 0; i < 4; i++) begin
        win_q[i]   <= win_q[i+4];
        win_q[i+4] <= next_w[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/aes_sbox.sv
// ------------------------------------------------
// Forward AES S-box, purely combinational
// Table form only, no masking
// ------------------------------------------------

`default_nettype none

module aes_sbox (
  input  logic [7:0] in_i,
  output logic [7:0] out_o
);

  // Row n holds entries 8n to 8n+7
  localparam logic [7:0] SboxTable [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  assign out_o = SboxTable[in_i];

endmodule

`default_nettype wire

//--- logic/csrng_pkg.sv
// ------------------------------------------------
// Shared widths and types for the block encrypt stage
// Bytes follow FIPS-197 order, byte 0 in the MSBs
// Only AES-256 in the forward direction exists
// ------------------------------------------------

`default_nettype none

package csrng_pkg;

  // Block and key widths
  localparam int unsigned BlkLen = 128;
  localparam int unsigned KeyLen = 256;

  // AES-256 round count
  localparam int unsigned NumRounds = 14;

  // Cipher state, V and round keys
  typedef logic [BlkLen-1:0] blk_t;

  // Full cipher key
  typedef logic [KeyLen-1:0] key_t;

  // One key schedule word
  typedef logic [31:0] word_t;

  // Round counter, holds 0 to 15
  typedef logic [3:0] round_cnt_t;

  // Cipher control states
  typedef enum logic [1:0] {
    CIPHER_IDLE,
    CIPHER_ROUND,
    CIPHER_DONE,
    CIPHER_ERROR
  } cipher_state_e;

endpackage

`default_nettype wire
